//--- hw/forth_find_pkg.sv
// forth lookup shared definitions
// widths, chain terminator and the state and select enums
package forth_find_pkg;

    localparam int dict_addr_w = 16;                // dictionary byte address
    localparam int name_max = 8;                    // longest word name in bytes
    localparam logic [dict_addr_w-1:0] link_end = '1; // end of a dictionary chain

    // word finder FSM, one state per field of an entry
    typedef enum logic [2:0] {
        IDLE,       // waiting for start
        LINK_LO,    // link low byte on rd_data
        LINK_HI,    // link high byte on rd_data
        LEN,        // name length on rd_data
        NAME,       // name byte on rd_data
        CODE_LO,    // code field low byte on rd_data
        CODE_HI,    // code field high byte on rd_data
        NEXT        // check saved link, issue read of entry
    } finder_state;

    // search coordinator FSM
    typedef enum logic [1:0] {
        WAIT_REQ,   // queue empty or finders idle
        SEARCH,     // both finders running
        REPLY       // response and credit out
    } coord_state;

    // which dictionary matched
    typedef enum logic {
        DICT_USER,
        DICT_CORE
    } dict_sel;

endpackage

//--- hw/dict_mem.sv
// dictionary memory
// byte wide, one registered read port and a load write port
module dict_mem import forth_find_pkg::*; #(
    parameter int DEPTH_LOG2 = 12               // 4K bytes by default
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [dict_addr_w-1:0] rd_addr,      // read address from finder
    input  logic                   load_en,      // testbench load strobe
    input  logic [dict_addr_w-1:0] load_addr,
    input  logic [7:0]             load_data,
    output logic [7:0]             rd_data       // byte at rd_addr, one cycle later
);

    logic [7:0] mem [0:(1 << DEPTH_LOG2) - 1];

    // load port, only upper bits beyond depth ignored
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[DEPTH_LOG2-1:0]] <= load_data;
        end
    end

    // registered read every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;                        // quiet bus after reset
        end else begin
            rd_data <= mem[rd_addr[DEPTH_LOG2-1:0]];
        end
    end

endmodule

//--- hw/word_finder.sv
// word finder
// walks one linked dictionary chain from head and compares each stored
// name to the requested one, returns hit and the code field address
module word_finder import forth_find_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,       // one cycle, name and len held
    input  logic [name_max*8-1:0]   name,        // byte 0 in low bits
    input  logic [3:0]              len,
    input  logic [dict_addr_w-1:0]  head,        // newest entry of the chain
    input  logic [7:0]              rd_data,     // byte read last cycle
    output logic [dict_addr_w-1:0]  rd_addr,
    output logic                    done,        // one cycle pulse
    output logic                    hit,         // held until next start
    output logic [dict_addr_w-1:0]  xt           // code field address on hit
);

    finder_state state;

    logic [dict_addr_w-1:0] link;               // entry being examined
    logic [dict_addr_w-1:0] next_link;          // link field of that entry
    logic [7:0]             link_lo;            // low byte until high arrives
    logic [2:0]             idx;                // name byte under compare
    logic [7:0]             want;               // requested byte at idx

    assign want = name[{idx, 3'b000} +: 8];

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            done  <= 1'b0;
            hit   <= 1'b0;
        end else begin
            done <= 1'b0;                       // pulse by default
            case (state)
                IDLE: begin
                    if (start) begin
                        hit   <= 1'b0;          // fresh search
                        state <= NEXT;
                    end
                end
                NEXT: begin
                    if (link == link_end) begin
                        done  <= 1'b1;          // chain exhausted, miss
                        state <= IDLE;
                    end else begin
                        state <= LINK_LO;
                    end
                end
                LINK_LO: state <= LINK_HI;
                LINK_HI: state <= LEN;
                LEN: begin
                    if (rd_data != {4'b0000, len}) begin
                        state <= NEXT;          // length differs, skip entry
                    end else if (len == 4'd0) begin
                        state <= CODE_LO;       // empty name, code field follows
                    end else begin
                        state <= NAME;
                    end
                end
                NAME: begin
                    if (rd_data != want) begin
                        state <= NEXT;          // first differing byte
                    end else if ({1'b0, idx} == len - 4'd1) begin
                        state <= CODE_LO;       // whole name matched
                    end
                end
                CODE_LO: state <= CODE_HI;
                CODE_HI: begin
                    done  <= 1'b1;
                    hit   <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address walk, one read issued ahead of each compare
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start) begin
                    link    <= head;
                    rd_addr <= head;            // link low byte next
                end
            end
            NEXT: rd_addr <= link + 1'b1;       // link high byte
            LINK_LO: begin
                link_lo <= rd_data;
                rd_addr <= rd_addr + 1'b1;      // length byte
            end
            LINK_HI: begin
                next_link <= {rd_data, link_lo};
                rd_addr   <= rd_addr + 1'b1;    // name byte 0
            end
            LEN: begin
                idx <= '0;
                if (rd_data != {4'b0000, len}) begin
                    link    <= next_link;       // follow the chain
                    rd_addr <= next_link;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
            NAME: begin
                if (rd_data != want) begin
                    link    <= next_link;
                    rd_addr <= next_link;
                end else begin
                    idx     <= idx + 1'b1;
                    rd_addr <= rd_addr + 1'b1;  // next name byte or code field
                end
            end
            CODE_LO: begin
                xt      <= rd_addr - 1'b1;      // address of code field low byte
                rd_addr <= rd_addr + 1'b1;
            end
            default: ;                          // CODE_HI holds
        endcase
    end

endmodule

//--- hw/search_coordinator.sv
// search coordinator
// queues requests under credit control, runs both finders on the queue
// head and merges their results, user dictionary first
module search_coordinator import forth_find_pkg::*; #(
    parameter int QUEUE_DEPTH = 2               // also initial credits
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  logic [name_max*8-1:0]   req_name,
    input  logic [3:0]              req_len,
    input  logic                    user_done,
    input  logic                    user_hit,
    input  logic [dict_addr_w-1:0]  user_xt,
    input  logic                    core_done,
    input  logic                    core_hit,
    input  logic [dict_addr_w-1:0]  core_xt,
    output logic                    credit,      // one credit back per response
    output logic                    rsp_valid,
    output logic                    rsp_hit,
    output dict_sel                 rsp_dict,
    output logic [dict_addr_w-1:0]  rsp_xt,
    output logic                    start,       // to both finders
    output logic [name_max*8-1:0]   name,        // queue head, steady until done
    output logic [3:0]              len
);

    localparam int ptr_w = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int cnt_w = $clog2(QUEUE_DEPTH + 1);

    coord_state state;

    logic [name_max*8-1:0] q_name [0:QUEUE_DEPTH-1];
    logic [3:0]            q_len  [0:QUEUE_DEPTH-1];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [cnt_w-1:0]      count;               // entries waiting or in search
    logic                  user_got;            // done seen from user finder
    logic                  core_got;
    logic                  pop;

    assign pop = (state == REPLY);

    // queue storage, credits guarantee a free slot
    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_name[wr_ptr] <= req_name;
            q_len[wr_ptr]  <= req_len;
        end
    end

    assign name = q_name[rd_ptr];
    assign len  = q_len[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            state    <= WAIT_REQ;
            start    <= 1'b0;
            user_got <= 1'b0;
            core_got <= 1'b0;
        end else begin
            start <= 1'b0;
            if (req_valid) begin
                wr_ptr <= (wr_ptr == ptr_w'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
            case (state)
                WAIT_REQ: begin
                    if (count != '0) begin
                        start    <= 1'b1;       // launch both finders
                        user_got <= 1'b0;
                        core_got <= 1'b0;
                        state    <= SEARCH;
                    end
                end
                SEARCH: begin
                    user_got <= user_got | user_done;
                    core_got <= core_got | core_done;
                    if ((user_got | user_done) && (core_got | core_done)) begin
                        state <= REPLY;
                    end
                end
                default: state <= WAIT_REQ;     // REPLY lasts one cycle
            endcase
        end
    end

    // merge, user redefinition shadows core
    assign rsp_valid = pop;
    assign credit    = pop;
    assign rsp_hit   = user_hit | core_hit;
    assign rsp_dict  = (core_hit && !user_hit) ? DICT_CORE : DICT_USER;
    assign rsp_xt    = user_hit ? user_xt : (core_hit ? core_xt : '0);

endmodule

//--- hw/forth_lookup_top.sv
// forth dictionary lookup top
// two dictionary memories each searched by its own finder, one coordinator
module forth_lookup_top import forth_find_pkg::*; #(
    parameter int QUEUE_DEPTH = 2,              // request credits
    parameter int DEPTH_LOG2  = 12              // bytes per dictionary, log2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [dict_addr_w-1:0]  head_user,   // newest user entry
    input  logic [dict_addr_w-1:0]  head_core,   // newest core entry
    input  logic                    load_en,
    input  dict_sel                 load_sel,    // which memory the load hits
    input  logic [dict_addr_w-1:0]  load_addr,
    input  logic [7:0]              load_data,
    input  logic                    req_valid,
    input  logic [name_max*8-1:0]   req_name,
    input  logic [3:0]              req_len,
    output logic                    credit,
    output logic                    rsp_valid,
    output logic                    rsp_hit,
    output dict_sel                 rsp_dict,
    output logic [dict_addr_w-1:0]  rsp_xt
);

    logic [dict_addr_w-1:0] user_rd_addr;
    logic [dict_addr_w-1:0] core_rd_addr;
    logic [7:0]             user_rd_data;
    logic [7:0]             core_rd_data;
    logic                   user_done;
    logic                   core_done;
    logic                   user_hit;
    logic                   core_hit;
    logic [dict_addr_w-1:0] user_xt;
    logic [dict_addr_w-1:0] core_xt;
    logic                   start;
    logic [name_max*8-1:0]  name;
    logic [3:0]             len;
    logic                   user_load_en;
    logic                   core_load_en;

    assign user_load_en = load_en && (load_sel == DICT_USER);
    assign core_load_en = load_en && (load_sel == DICT_CORE);

    dict_mem #(.DEPTH_LOG2(DEPTH_LOG2)) u_user_mem (
        .clk(clk), .rst(rst),
        .rd_addr(user_rd_addr), .load_en(user_load_en),
        .load_addr(load_addr), .load_data(load_data),
        .rd_data(user_rd_data)
    );

    dict_mem #(.DEPTH_LOG2(DEPTH_LOG2)) u_core_mem (
        .clk(clk), .rst(rst),
        .rd_addr(core_rd_addr), .load_en(core_load_en),
        .load_addr(load_addr), .load_data(load_data),
        .rd_data(core_rd_data)
    );

    word_finder u_user_finder (
        .clk(clk), .rst(rst), .start(start), .name(name), .len(len),
        .head(head_user), .rd_data(user_rd_data), .rd_addr(user_rd_addr),
        .done(user_done), .hit(user_hit), .xt(user_xt)
    );

    word_finder u_core_finder (
        .clk(clk), .rst(rst), .start(start), .name(name), .len(len),
        .head(head_core), .rd_data(core_rd_data), .rd_addr(core_rd_addr),
        .done(core_done), .hit(core_hit), .xt(core_xt)
    );

    search_coordinator #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_coord (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_name(req_name), .req_len(req_len),
        .user_done(user_done), .user_hit(user_hit), .user_xt(user_xt),
        .core_done(core_done), .core_hit(core_hit), .core_xt(core_xt),
        .credit(credit), .rsp_valid(rsp_valid), .rsp_hit(rsp_hit),
        .rsp_dict(rsp_dict), .rsp_xt(rsp_xt),
        .start(start), .name(name), .len(len)
    );

endmodule

//--- tests/forth_lookup_assert.sv
// credit and finder protocol checks
// bound into the search coordinator, tracks credits held and finder activity
module forth_lookup_assert #(
    parameter int QUEUE_DEPTH = 2
) (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic credit,
    input logic rsp_valid,
    input logic start,
    input logic user_done,
    input logic core_done
);
    timeunit 1ns;
    timeprecision 100ps;

    int   held;                                 // credits on the requester side
    logic user_busy;                            // user finder between start and done
    logic core_busy;
    int   fails = 0;                            // assertion failures so far

    always_ff @(posedge clk) begin
        if (rst) begin
            held      <= QUEUE_DEPTH;
            user_busy <= 1'b0;
            core_busy <= 1'b0;
        end else begin
            held <= held - int'(req_valid) + int'(credit);
            if (start) begin
                user_busy <= 1'b1;
                core_busy <= 1'b1;
            end else begin
                if (user_done) user_busy <= 1'b0;
                if (core_done) core_busy <= 1'b0;
            end
        end
    end

    req_has_credit: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> held > 0)
        else begin
            $error("request sent with no credit held");
            fails++;
        end

    rsp_for_request: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> held < QUEUE_DEPTH)
        else begin
            $error("response with no request outstanding");
            fails++;
        end

    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !user_busy && !core_busy)
        else begin
            $error("start raised while a finder is still searching");
            fails++;
        end

endmodule

//--- tests/tb_clkgen.sv
// testbench clock and reset source
// free running clock, reset held high for a fixed number of cycles
module tb_clkgen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #(period_ns / 2) clk = ~clk;         // 50 percent duty

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;                          // released off the edge like other inputs
    end

endmodule

//--- tests/tb_forth_lookup.sv
// forth lookup testbench
// builds both dictionaries through the load port, sends names under credit
// control and checks every response against a chain walking model
module tb_forth_lookup import forth_find_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int queue_depth = 2;             // initial credits, same as UUT
    localparam int n_random    = 200;
    localparam int n_bursts    = 3;
    localparam int user_base   = 'h020;
    localparam int core_base   = 'h100;

    logic clk;
    logic rst;
    logic [dict_addr_w-1:0] head_user;
    logic [dict_addr_w-1:0] head_core;
    logic load_en;
    dict_sel load_sel;
    logic [dict_addr_w-1:0] load_addr;
    logic [7:0] load_data;
    logic req_valid;
    logic [name_max*8-1:0] req_name;
    logic [3:0] req_len;
    logic credit;
    logic rsp_valid;
    logic rsp_hit;
    dict_sel rsp_dict;
    logic [dict_addr_w-1:0] rsp_xt;

    logic [7:0] img [0:1][0:4095];              // index 0 user, 1 core
    logic [15:0] head [0:1];
    int top [0:1];                              // next free byte
    int walk [0:1];                             // worst walk cycles per chain
    string known [$];                           // every defined name
    string directed [$];
    logic [17:0] exp_q [$];                     // {hit, dict, xt}
    logic [17:0] e;
    int credits = queue_depth;
    int errors = 0;
    int checks = 0;
    int responses = 0;
    int cyc = 0;
    int limit = 0;
    int assert_fails;

    tb_clkgen #(.period_ns(4), .reset_cycles(8)) u_clkgen (.clk(clk), .rst(rst));

    forth_lookup_top #(.QUEUE_DEPTH(queue_depth), .DEPTH_LOG2(12)) UUT (
        .clk(clk), .rst(rst), .head_user(head_user), .head_core(head_core),
        .load_en(load_en), .load_sel(load_sel), .load_addr(load_addr),
        .load_data(load_data), .req_valid(req_valid), .req_name(req_name),
        .req_len(req_len), .credit(credit), .rsp_valid(rsp_valid),
        .rsp_hit(rsp_hit), .rsp_dict(rsp_dict), .rsp_xt(rsp_xt)
    );

    bind search_coordinator forth_lookup_assert #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_assert (
        .clk(clk), .rst(rst), .req_valid(req_valid), .credit(credit),
        .rsp_valid(rsp_valid), .start(start), .user_done(user_done),
        .core_done(core_done)
    );

    task automatic check(input string sig, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", sig, got, exp);
        end
    endtask

    function automatic logic [63:0] pack_name(input string s);
        logic [63:0] v;
        int i;
        v = '0;
        for (i = 0; i < s.len(); i++) begin
            v[i*8 +: 8] = s[i];                 // byte 0 in low bits
        end
        return v;
    endfunction

    // append one entry in front of a chain
    task automatic add_word(input int d, input string s);
        int a;
        int i;
        a = top[d];
        img[d][a]     = head[d][7:0];
        img[d][a + 1] = head[d][15:8];
        img[d][a + 2] = 8'(s.len());
        for (i = 0; i < s.len(); i++) begin
            img[d][a + 3 + i] = s[i];
        end
        img[d][a + 3 + s.len()] = 8'($urandom);    // code field contents are arbitrary
        img[d][a + 4 + s.len()] = 8'($urandom);
        head[d] = 16'(a);
        top[d]  = a + 5 + s.len();
        walk[d] += s.len() + 6;
        known.push_back(s);
    endtask

    // walks the user chain and then the core chain from the newest entry
    function automatic logic [17:0] ref_lookup(input logic [63:0] nm, input logic [3:0] ln);
        int d;
        int a;
        int i;
        bit same;
        bit found;
        bit which;
        logic [15:0] xt;
        found = 1'b0;
        which = 1'b0;
        xt = '0;
        for (d = 0; d < 2 && !found; d++) begin
            a = int'(head[d]);
            while (!found && a != int'(link_end)) begin
                same = (img[d][a + 2] == {4'b0000, ln});
                for (i = 0; same && i < int'(ln); i++) begin
                    if (img[d][a + 3 + i] != nm[i*8 +: 8]) same = 1'b0;
                end
                if (same) begin
                    found = 1'b1;
                    which = (d == 1);
                    xt = 16'(a + 3 + int'(ln));     // code field low byte
                end else begin
                    a = int'({img[d][a + 1], img[d][a]});
                end
            end
        end
        return {found, which, xt};
    endfunction

    task automatic load_dicts();
        int d;
        int a;
        for (d = 0; d < 2; d++) begin
            for (a = (d == 0) ? user_base : core_base; a < top[d]; a++) begin
                @(posedge clk);
                #1;
                load_en   = 1'b1;
                load_sel  = (d == 0) ? DICT_USER : DICT_CORE;
                load_addr = 16'(a);
                load_data = img[d][a];
            end
        end
        @(posedge clk);
        #1 load_en = 1'b0;
    endtask

    // leaves req_valid high so the next call can follow back to back
    task automatic send_req(input logic [63:0] nm, input logic [3:0] ln);
        @(posedge clk);
        #1;
        while (credits == 0) begin
            req_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b1;
        req_name  = nm;
        req_len   = ln;
        credits--;
        exp_q.push_back(ref_lookup(nm, ln));
    endtask

    task automatic idle_req();
        @(posedge clk);
        #1 req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    always @(posedge clk) cyc++;

    // outputs sampled on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (credit || rsp_valid) begin
                check("credit", 32'(credit), 32'(rsp_valid));   // one credit per response
            end
            if (credit) credits++;
            if (rsp_valid) begin
                responses++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response arrived with no request outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check("rsp_hit", 32'(rsp_hit), 32'(e[17]));
                    if (e[17]) begin
                        check("rsp_dict", 32'(rsp_dict), 32'(e[16]));
                        check("rsp_xt", 32'(rsp_xt), 32'(e[15:0]));
                    end
                end
            end
        end
    end

    initial begin
        wait (limit != 0);
        while (cyc <= limit) @(posedge clk);
        $display("timeout, run still going after %0d cycles", limit);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int i;
        int k;
        int max_walk;
        logic [63:0] nm;
        logic [3:0] ln;
        void'($urandom(27602));
        req_valid = 1'b0;
        req_name  = '0;
        req_len   = '0;
        load_en   = 1'b0;
        load_sel  = DICT_USER;
        load_addr = '0;
        load_data = '0;
        head_user = link_end;                   // empty chains until loaded
        head_core = link_end;
        head[0] = link_end;
        head[1] = link_end;
        top[0]  = user_base;
        top[1]  = core_base;
        walk[0] = 0;
        walk[1] = 0;
        add_word(1, "DUP");
        add_word(1, "DROP");
        add_word(1, "SWAP");
        add_word(1, "OVER");
        add_word(1, "ROT");
        add_word(1, "EMIT");
        add_word(1, "KEY");
        add_word(1, "CREATE");
        add_word(1, "ALLOT");
        add_word(1, "HERE");
        add_word(0, "SQUARE");
        add_word(0, "CUBE");
        add_word(0, "DUP");                     // shadows core DUP
        add_word(0, "NIP2");
        add_word(0, "EMIT");
        add_word(0, "CUBE");                    // newer CUBE wins in its own chain
        directed = '{"SWAP", "HERE", "ALLOT", "SQUARE", "NIP2", "CUBE", "DUP", "EMIT",
                     "DRO", "SWAQ", "CUBES", "SQUAR", "XYZ"};
        max_walk = ((walk[0] > walk[1]) ? walk[0] : walk[1]) + 8;
        limit = (top[0] - user_base) + (top[1] - core_base) + 20
              + (directed.size() + n_bursts * queue_depth + n_random) * max_walk * 2;
        while (rst) @(posedge clk);
        load_dicts();
        head_user = head[0];
        head_core = head[1];
        for (i = 0; i < directed.size(); i++) begin
            send_req(pack_name(directed[i]), 4'(directed[i].len()));
        end
        idle_req();
        drain();
        for (i = 0; i < n_bursts; i++) begin
            check("credits", 32'(credits), 32'(queue_depth));  // all returned by the DUT
            for (k = 0; k < queue_depth; k++) begin
                send_req(pack_name(known[i + k]), 4'(known[i + k].len()));
            end
            idle_req();
            drain();
        end
        for (i = 0; i < n_random; i++) begin
            if (($urandom % 2) == 0) begin
                k  = int'($urandom % 32'(known.size()));
                nm = pack_name(known[k]);
                ln = 4'(known[k].len());
                if (($urandom % 4) == 0) begin
                    nm[(int'(ln) - 1)*8 +: 8] = nm[(int'(ln) - 1)*8 +: 8] ^ 8'h01;
                end
            end else begin
                ln = 4'(1 + $urandom % 8);
                nm = '0;
                for (k = 0; k < int'(ln); k++) begin
                    nm[k*8 +: 8] = 8'h41 + 8'($urandom % 26);    // upper case letters
                end
            end
            for (k = int'(ln); k < name_max; k++) begin
                nm[k*8 +: 8] = 8'($urandom);    // junk past len must be ignored
            end
            send_req(nm, ln);
        end
        idle_req();
        drain();
        check("credits", 32'(credits), 32'(queue_depth));
        assert_fails = UUT.u_coord.u_assert.fails;
        $display("checks %0d responses %0d errors %0d assertion failures %0d",
                 checks, responses, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb.f
hw/forth_find_pkg.sv
hw/dict_mem.sv
hw/word_finder.sv
hw/search_coordinator.sv
hw/forth_lookup_top.sv
tests/forth_lookup_assert.sv
tests/tb_clkgen.sv
tests/tb_forth_lookup.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_forth_lookup
FILELIST  := tb.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000

SOURCES := $(wildcard hw/*.sv) $(wildcard tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
